// ==== hw/adc_cmd_pkg.sv ====
package adc_cmd_pkg;

  ////////////////////////////////////////////////////////////
  // Command word layout
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] cmd_word_t;  // Raw word from the command buffer

  // Opcode field, bits 31:30
  typedef enum logic [1:0] {
    NO_OP   = 2'b00,  // Delay or trigger wait
    ADC_RD  = 2'b01,  // Nine-frame sample read
    SET_ORD = 2'b10,  // Load channel order table
    CANCEL  = 2'b11   // End a pending wait
  } cmd_op_t;

  localparam int CMD_OP_LSB   = 30;  // Low bit of the opcode field
  localparam int CMD_TRIG_BIT = 29;  // Wait on triggers instead of cycles
  localparam int CMD_CONT_BIT = 28;  // Another command must follow

  typedef logic [25:0] count_t;  // Delay cycles or trigger count, bits 25:0
  typedef logic [2:0]  chan_t;   // ADC channel number

  // Eight 3-bit slots, slot 0 in bits 2:0
  typedef logic [23:0] order_t;

  // Output word, later sample in the upper half
  typedef logic [31:0] data_word_t;

endpackage

// ==== hw/adc_spi_pkg.sv ====
package adc_spi_pkg;

  ////////////////////////////////////////////////////////////
  // SPI frame
  ////////////////////////////////////////////////////////////

  typedef logic [15:0] spi_word_t;  // One on-the-fly frame
  typedef logic [7:0]  cs_cnt_t;    // Chip-select gap counter

  localparam int SPI_FRAME_BITS  = 16;
  localparam int FRAMES_PER_READ = 9;  // Eight requests plus one flush frame

  // Sample request: prefix, channel, eleven zeros
  localparam logic [1:0] SAMPLE_REQ_PREFIX = 2'd2;

  ////////////////////////////////////////////////////////////
  // ADC timing
  ////////////////////////////////////////////////////////////

  localparam int SPI_CLK_HZ = 20_000_000;  // Rate of clk

  localparam int T_CONV_NS_M8  = 660;   // Conversion time per model
  localparam int T_CONV_NS_M7  = 1200;
  localparam int T_CONV_NS_M6  = 2500;
  localparam int T_CYCLE_NS_M8 = 1000;  // Minimum cycle period per model
  localparam int T_CYCLE_NS_M7 = 2000;
  localparam int T_CYCLE_NS_M6 = 4000;

  // Gap is max of 3, conversion cycles and (cycle-period cycles - frame bits)
  function automatic int cs_high_cycles_for(int model_id);
    int clk_mhz;
    int conv_ns;
    int cycle_ns;
    int conv_cyc;
    int cycle_cyc;
    int gap;
    clk_mhz  = SPI_CLK_HZ / 1_000_000;
    conv_ns  = (model_id == 8) ? T_CONV_NS_M8 : (model_id == 7) ? T_CONV_NS_M7 : T_CONV_NS_M6;
    cycle_ns = (model_id == 8) ? T_CYCLE_NS_M8 :
               (model_id == 7) ? T_CYCLE_NS_M7 : T_CYCLE_NS_M6;
    conv_cyc  = (conv_ns * clk_mhz + 999) / 1000;  // Round up to whole cycles
    cycle_cyc = (cycle_ns * clk_mhz + 999) / 1000 - SPI_FRAME_BITS;
    gap = (conv_cyc > cycle_cyc) ? conv_cyc : cycle_cyc;
    return (gap > 3) ? gap : 3;
  endfunction

endpackage

// ==== hw/adc_cmd_sequencer.sv ====
`timescale 1ns/1ps

module adc_cmd_sequencer (
  input  logic                   clk,
  input  logic                   resetn,
  input  adc_cmd_pkg::cmd_word_t cmd_word,
  input  logic                   cmd_buf_empty,
  input  logic                   trigger,
  input  logic                   delay_zero,
  input  logic                   trig_zero,
  input  logic                   read_done,
  input  logic                   write_blocked,
  output logic                   cmd_word_rd_en,
  output logic                   load_delay,
  output logic                   load_trig,
  output adc_cmd_pkg::count_t    load_count,
  output logic                   clear,
  output logic                   start_read,
  output logic                   order_load,
  output adc_cmd_pkg::order_t    order_word,
  output logic                   halt,
  output logic                   waiting_for_trig,
  output logic                   cmd_buf_underflow,
  output logic                   data_buf_overflow,
  output logic                   unexp_trig,
  output logic                   delay_too_short
);

  import adc_cmd_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_DELAY, S_TRIG_WAIT, S_ADC_RD, S_HALT} state_t;

  state_t  state;
  state_t  next_state;
  cmd_op_t op;           // Opcode of the word at the buffer head
  logic    is_wait_cmd;  // NO_OP or ADC_RD, both carry a count
  logic    wait_for_trig;
  logic    expect_next;
  logic    cmd_done;
  logic    cancel_wait;
  logic    pop;
  logic    err_underflow;
  logic    err_trig;
  logic    err_short;
  logic    error;

  assign op          = cmd_op_t'(cmd_word[CMD_OP_LSB +: 2]);
  assign is_wait_cmd = (op == NO_OP) || (op == ADC_RD);

  ////////////////////////////////////////////////////////////
  // Command completion and pop
  ////////////////////////////////////////////////////////////

  assign cmd_done = (state == S_IDLE && !cmd_buf_empty)
                    || (state == S_DELAY && delay_zero)
                    || (state == S_TRIG_WAIT && trigger && trig_zero)
                    || (state == S_ADC_RD && read_done && !wait_for_trig && delay_zero);

  // CANCEL at the head ends any wait, including the one right after a read
  assign cancel_wait = (state == S_DELAY || state == S_TRIG_WAIT
                        || (state == S_ADC_RD && read_done))
                       && !cmd_buf_empty && (op == CANCEL);

  assign pop            = (state != S_HALT) && !cmd_buf_empty && (cmd_done || cancel_wait);
  assign cmd_word_rd_en = pop;

  // Error rules
  assign err_underflow = cmd_done && expect_next && cmd_buf_empty;
  assign err_trig      = (state != S_TRIG_WAIT) && trigger && trig_zero;  // Nobody waiting
  assign err_short     = (state == S_ADC_RD) && !read_done && !wait_for_trig && delay_zero;
  assign error         = err_underflow || err_trig || err_short || write_blocked;

  always_comb begin
    next_state = state;
    if (error) next_state = S_HALT;
    else if (state == S_HALT) next_state = S_HALT;  // Only reset leaves
    else if (cancel_wait) next_state = S_IDLE;
    else if (cmd_done) begin
      if (cmd_buf_empty) next_state = S_IDLE;
      else begin
        case (op)
          NO_OP:   next_state = cmd_word[CMD_TRIG_BIT] ? S_TRIG_WAIT : S_DELAY;
          ADC_RD:  next_state = S_ADC_RD;
          default: next_state = S_IDLE;  // SET_ORD and CANCEL finish at once
        endcase
      end
    end else if (state == S_ADC_RD && read_done) begin
      next_state = wait_for_trig ? S_TRIG_WAIT : S_DELAY;  // Post-read wait
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) state <= S_IDLE;
    else state <= next_state;
  end

  // Trigger and continue bits of the running command
  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      wait_for_trig <= 1'b0;
      expect_next   <= 1'b0;
    end else if (pop) begin
      wait_for_trig <= is_wait_cmd && cmd_word[CMD_TRIG_BIT];
      expect_next   <= is_wait_cmd && cmd_word[CMD_CONT_BIT];
    end
  end

  // Sticky flags
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cmd_buf_underflow <= 1'b0;
      data_buf_overflow <= 1'b0;
      unexp_trig        <= 1'b0;
      delay_too_short   <= 1'b0;
    end else begin
      if (err_underflow) cmd_buf_underflow <= 1'b1;
      if (write_blocked) data_buf_overflow <= 1'b1;
      if (err_trig) unexp_trig <= 1'b1;
      if (err_short) delay_too_short <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Strobes to timers and engine
  ////////////////////////////////////////////////////////////

  assign load_delay       = pop && is_wait_cmd && !cmd_word[CMD_TRIG_BIT];
  assign load_trig        = pop && is_wait_cmd && cmd_word[CMD_TRIG_BIT];
  assign load_count       = count_t'(cmd_word);  // Bits 25:0
  assign halt             = (state == S_HALT);
  assign clear            = halt || cancel_wait;
  assign start_read       = pop && (op == ADC_RD);
  assign order_load       = pop && (op == SET_ORD);
  assign order_word       = order_t'(cmd_word);  // Bits 23:0
  assign waiting_for_trig = (state == S_TRIG_WAIT);

endmodule

// ==== hw/adc_wait_timers.sv ====
`timescale 1ns/1ps

module adc_wait_timers (
  input  logic                clk,
  input  logic                resetn,
  input  logic                load_delay,
  input  logic                load_trig,
  input  adc_cmd_pkg::count_t load_count,
  input  logic                clear,
  input  logic                trigger,
  output logic                delay_zero,
  output logic                trig_zero
);

  import adc_cmd_pkg::*;

  count_t delay_cnt;  // Cycles left
  count_t trig_cnt;   // Triggers left before the final one

  // Delay counter, one step per cycle
  always_ff @(posedge clk) begin
    if (!resetn || clear) delay_cnt <= '0;
    else if (load_delay) delay_cnt <= load_count;
    else if (delay_cnt != '0) delay_cnt <= delay_cnt - 1'b1;  // Hold at zero
  end

  // Trigger counter, one step per trigger
  always_ff @(posedge clk) begin
    if (!resetn || clear) trig_cnt <= '0;
    else if (load_trig) trig_cnt <= load_count;
    else if (trigger && trig_cnt != '0) trig_cnt <= trig_cnt - 1'b1;
  end

  assign delay_zero = (delay_cnt == '0);
  assign trig_zero  = (trig_cnt == '0);  // Next trigger ends the wait

endmodule

// ==== hw/adc_spi_engine.sv ====
`timescale 1ns/1ps

module adc_spi_engine #(
  parameter int cs_high_cycles = 14  // n_cs high time between frames
) (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   start_read,
  input  logic                   order_load,
  input  adc_cmd_pkg::order_t    order_word,
  input  logic                   halt,
  input  logic                   miso,
  output logic                   read_done,
  output logic                   sample_valid,
  output adc_spi_pkg::spi_word_t sample,
  output logic                   n_cs,
  output logic                   mosi
);

  import adc_cmd_pkg::*;
  import adc_spi_pkg::*;

  localparam cs_cnt_t    GAP_LOAD   = cs_cnt_t'(cs_high_cycles - 1);
  localparam logic [3:0] LAST_FRAME = 4'(FRAMES_PER_READ);
  localparam logic [3:0] LAST_BIT   = 4'(SPI_FRAME_BITS - 1);

  chan_t      order_tbl [8];  // Channel per slot
  logic       active;         // Read in progress
  logic [3:0] frame_idx;      // 1 to 9
  cs_cnt_t    cs_cnt;
  logic [3:0] bit_cnt;
  spi_word_t  mosi_sr;
  spi_word_t  miso_sr;
  chan_t      req_chan;

  function automatic spi_word_t sample_req(chan_t ch);
    return {SAMPLE_REQ_PREFIX, ch, 11'd0};
  endfunction

  ////////////////////////////////////////////////////////////
  // Channel order table
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < 8; i++) order_tbl[i] <= chan_t'(i);  // Default 0..7
    end else if (order_load) begin
      for (int i = 0; i < 8; i++) order_tbl[i] <= order_word[3*i +: 3];
    end
  end

  // Frame k asks for slot k-1, flush frame asks for channel 0
  assign req_chan = (frame_idx == LAST_FRAME) ? chan_t'(0) : order_tbl[3'(frame_idx - 4'd1)];

  ////////////////////////////////////////////////////////////
  // Frame sequencing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    read_done    <= 1'b0;  // Pulses by default
    sample_valid <= 1'b0;
    if (!resetn || halt) begin
      active    <= 1'b0;
      n_cs      <= 1'b1;
      frame_idx <= '0;
      cs_cnt    <= '0;
      bit_cnt   <= '0;
      mosi_sr   <= '0;
    end else if (start_read) begin
      active    <= 1'b1;
      frame_idx <= 4'd1;
      cs_cnt    <= GAP_LOAD;
    end else if (active && n_cs) begin
      // Gap, then drop n_cs with bit 15 on MOSI
      if (cs_cnt != '0) cs_cnt <= cs_cnt - 1'b1;
      else begin
        n_cs    <= 1'b0;
        bit_cnt <= LAST_BIT;
        mosi_sr <= sample_req(req_chan);
      end
    end else if (active) begin
      mosi_sr <= {mosi_sr[14:0], 1'b0};  // Next bit out
      if (bit_cnt != '0) bit_cnt <= bit_cnt - 1'b1;
      else begin
        n_cs         <= 1'b1;  // 16 cycles low done
        cs_cnt       <= GAP_LOAD;
        sample_valid <= (frame_idx != 4'd1);  // Frame 1 returns nothing useful
        if (frame_idx == LAST_FRAME) begin
          active    <= 1'b0;
          read_done <= 1'b1;
        end else begin
          frame_idx <= frame_idx + 4'd1;
        end
      end
    end
  end

  // MISO capture, MSB first, same edges as MOSI shifts
  always_ff @(posedge clk) begin
    if (!n_cs) miso_sr <= {miso_sr[14:0], miso};
  end

  assign sample = miso_sr;  // Complete in the cycle after n_cs rises
  assign mosi   = mosi_sr[15];

endmodule

// ==== hw/adc_sample_packer.sv ====
`timescale 1ns/1ps

module adc_sample_packer (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    sample_valid,
  input  adc_spi_pkg::spi_word_t  sample,
  input  logic                    halt,
  input  logic                    data_buf_full,
  output adc_cmd_pkg::data_word_t data_word,
  output logic                    data_word_wr_en,
  output logic                    write_blocked
);

  import adc_spi_pkg::*;

  spi_word_t first_sample;  // Earlier half of the pair
  logic      half_valid;    // First sample held

  ////////////////////////////////////////////////////////////
  // Pair tracking and write strobes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    data_word_wr_en <= 1'b0;
    write_blocked   <= 1'b0;
    if (!resetn || halt) begin
      half_valid <= 1'b0;  // Drop any half pair
    end else if (sample_valid) begin
      half_valid <= !half_valid;
      if (half_valid) begin
        // Second sample, write now or flag the full buffer
        if (data_buf_full) write_blocked <= 1'b1;
        else data_word_wr_en <= 1'b1;
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (sample_valid && !half_valid) first_sample <= sample;
    if (sample_valid && half_valid) data_word <= {sample, first_sample};  // Later on top
  end

endmodule

// ==== hw/adc_ctrl_top.sv ====
`timescale 1ns/1ps

module adc_ctrl_top #(
  parameter int adc_model_id = 8  // ADC model: 8, 7 or 6
) (
  input  logic                    clk,
  input  logic                    resetn,
  input  adc_cmd_pkg::cmd_word_t  cmd_word,
  input  logic                    cmd_buf_empty,
  output logic                    cmd_word_rd_en,
  output adc_cmd_pkg::data_word_t data_word,
  output logic                    data_word_wr_en,
  input  logic                    data_buf_full,
  input  logic                    trigger,
  output logic                    waiting_for_trig,
  output logic                    cmd_buf_underflow,
  output logic                    data_buf_overflow,
  output logic                    unexp_trig,
  output logic                    delay_too_short,
  output logic                    n_cs,
  output logic                    mosi,
  input  logic                    miso
);

  import adc_cmd_pkg::*;
  import adc_spi_pkg::*;

  localparam int cs_high_cycles = cs_high_cycles_for(adc_model_id);

  // Sequencer to timers
  logic      load_delay;
  logic      load_trig;
  count_t    load_count;
  logic      clear;
  logic      delay_zero;
  logic      trig_zero;
  // Sequencer, engine and packer
  logic      start_read;
  logic      order_load;
  order_t    order_word;
  logic      halt;
  logic      read_done;
  logic      sample_valid;
  spi_word_t sample;
  logic      write_blocked;

  ////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////

  adc_cmd_sequencer u_seq (
    .clk, .resetn, .cmd_word, .cmd_buf_empty, .trigger,
    .delay_zero, .trig_zero, .read_done, .write_blocked,
    .cmd_word_rd_en, .load_delay, .load_trig, .load_count, .clear,
    .start_read, .order_load, .order_word, .halt, .waiting_for_trig,
    .cmd_buf_underflow, .data_buf_overflow, .unexp_trig, .delay_too_short
  );

  adc_wait_timers u_timers (
    .clk, .resetn, .load_delay, .load_trig, .load_count, .clear, .trigger,
    .delay_zero, .trig_zero
  );

  adc_spi_engine #(
    .cs_high_cycles(cs_high_cycles)
  ) u_engine (
    .clk, .resetn, .start_read, .order_load, .order_word, .halt, .miso,
    .read_done, .sample_valid, .sample, .n_cs, .mosi
  );

  adc_sample_packer u_packer (
    .clk, .resetn, .sample_valid, .sample, .halt, .data_buf_full,
    .data_word, .data_word_wr_en, .write_blocked
  );

endmodule

// ==== verif/tb_adc_ctrl_util.svh ====
`ifndef TB_ADC_CTRL_UTIL_SVH
`define TB_ADC_CTRL_UTIL_SVH

////////////////////////////////////////////////////////////
// Random bits
////////////////////////////////////////////////////////////

// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
  return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return r;
endfunction

////////////////////////////////////////////////////////////
// Command builders
////////////////////////////////////////////////////////////

function automatic cmd_word_t make_wait_cmd(cmd_op_t op, logic trig, logic cont, count_t cnt);
  return {op, trig, cont, 2'b00, cnt};  // Op, trigger, continue, spare, count
endfunction

function automatic cmd_word_t make_order_cmd(order_t ord);
  return {SET_ORD, 6'b0, ord};
endfunction

// Pair p holds slot 2p low and slot 2p+1 high with counts in frame order
function automatic data_word_t exp_word(int p);
  spi_word_t lo;
  spi_word_t hi;
  lo = {cur_order[2*p], 13'(2*p)};
  hi = {cur_order[2*p+1], 13'(2*p+1)};
  return {hi, lo};
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_word(string name, data_word_t expected, data_word_t actual);
  if (expected !== actual) begin
    $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    test_errs++;
  end
endtask

task automatic check_flag(string name, logic expected, logic actual);
  if (expected !== actual) begin
    $display("FAILED %s: expected %b, actual %b", name, expected, actual);
    test_errs++;
  end
endtask

`endif

// ==== verif/tb_adc_ctrl.sv ====
`timescale 1ns/1ps

module tb_adc_ctrl;
  import adc_cmd_pkg::*;
  import adc_spi_pkg::*;

  logic       clk;
  logic       resetn;
  logic       trigger;
  logic       data_buf_full;
  cmd_word_t  cmd_word = '0;
  logic       cmd_buf_empty = 1'b1;
  logic       miso = 1'b0;
  logic       cmd_word_rd_en;
  logic       data_word_wr_en;
  logic       waiting_for_trig;
  logic       n_cs;
  logic       mosi;
  logic       cmd_buf_underflow;
  logic       data_buf_overflow;
  logic       unexp_trig;
  logic       delay_too_short;
  data_word_t data_word;

  logic [31:0] lfsr_state = 32'had9;
  cmd_word_t   cmd_q[$];     // Command buffer contents
  data_word_t  got[$];       // Words written by the DUT
  logic        wr_seen;
  chan_t       cur_order[8]; // Mirror of the order table
  int          test_errs;
  int          tests_run;
  int          tests_failed;
  spi_word_t   rx;           // ADC model shift words
  spi_word_t   tx;
  int          bit_idx;
  int          sample_cnt;
  int          n_trig;
  order_t      ord;

  `include "tb_adc_ctrl_util.svh"

  adc_ctrl_top #(.adc_model_id(8)) u_adc_ctrl_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin  // Hang guard
    #50_000_000;
    $display("Simulation time limit reached");
    $display("Testbench failed");
    $finish;
  end

  // FWFT command buffer that pops only out of reset
  always @(posedge clk) begin
    if (resetn && cmd_word_rd_en && cmd_q.size() > 0) void'(cmd_q.pop_front());
    cmd_buf_empty <= (cmd_q.size() == 0);
    cmd_word      <= (cmd_q.size() > 0) ? cmd_q[0] : '0;
  end

  // Data buffer side
  always @(posedge clk) begin
    if (resetn && data_word_wr_en) begin
      got.push_back(data_word);
      wr_seen = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // ADC model answering each request in the next frame
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!resetn) begin
      bit_idx = 0;
      sample_cnt = 0;
      tx = '0;
      miso <= 1'b0;
    end else if (!n_cs) begin
      rx = {rx[14:0], mosi};
      if (bit_idx == 15) begin
        if (rx[15:14] != SAMPLE_REQ_PREFIX || rx[10:0] != 11'd0) begin
          $display("ADC model got a malformed request frame %h", rx);
          test_errs++;
        end
        tx = {rx[13:11], 13'(sample_cnt)};  // Channel on top, running count
        sample_cnt++;
        bit_idx = 0;
        miso <= tx[15];
      end else begin
        bit_idx++;
        miso <= tx[15 - bit_idx];
      end
    end else begin
      miso <= tx[15];  // Ready for the first low edge
    end
  end

  task automatic reset_dut();
    @(posedge clk);
    resetn <= 1'b0;
    trigger <= 1'b0;
    data_buf_full <= 1'b0;
    @(negedge clk);
    cmd_q.delete();
    repeat (2) @(posedge clk);
    resetn <= 1'b1;
    @(negedge clk);
    got.delete();
    wr_seen = 1'b0;
    test_errs = 0;
    for (int i = 0; i < 8; i++) cur_order[i] = chan_t'(i);
  endtask

  task automatic push_cmd(cmd_word_t w);
    @(negedge clk);  // Away from the buffer's edge
    cmd_q.push_back(w);
  endtask

  task automatic wait_words(string name, int n, int limit);
    int t;
    t = 0;
    while (got.size() < n && t < limit) begin
      @(negedge clk);
      t++;
    end
    if (got.size() < n) begin
      $display("%s: timed out waiting for %0d data words", name, n);
      test_errs++;
    end
  endtask

  function automatic logic flag_value(int idx);
    case (idx)
      0: return cmd_buf_underflow;
      1: return data_buf_overflow;
      2: return unexp_trig;
      3: return delay_too_short;
      default: return waiting_for_trig;
    endcase
  endfunction

  task automatic wait_flag(string name, int idx, int limit);
    int t;
    t = 0;
    while (flag_value(idx) !== 1'b1 && t < limit) begin
      @(negedge clk);
      t++;
    end
    if (flag_value(idx) !== 1'b1) begin
      $display("%s: timed out waiting for a flag", name);
      test_errs++;
    end
  endtask

  task automatic check_read(string name);
    wait_words(name, 4, 3000);
    for (int p = 0; p < 4 && p < got.size(); p++)
      check_word($sformatf("%s word %0d", name, p), exp_word(p), got[p]);
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %s: %0s", name, (test_errs == 0) ? "ok" : "errors found");
  endtask

  initial begin
    resetn = 1'b0;
    trigger = 1'b0;
    data_buf_full = 1'b0;
    tests_run = 0;
    tests_failed = 0;
    test_errs = 0;
    // Test 1 with default order and long delay
    reset_dut();
    push_cmd(make_wait_cmd(ADC_RD, 1'b0, 1'b0, count_t'(300 + rand_bits(9))));
    check_read("default_order");
    for (int i = 0; i < 4; i++)
      check_flag($sformatf("default_order flag %0d", i), 1'b0, flag_value(i));
    finish_test("default_order");
    // Test 2 with a random order
    reset_dut();
    ord = order_t'(rand_bits(24));
    push_cmd(make_order_cmd(ord));
    push_cmd(make_wait_cmd(ADC_RD, 1'b0, 1'b0, count_t'(300 + rand_bits(9))));
    for (int i = 0; i < 8; i++) cur_order[i] = ord[3*i +: 3];
    check_read("set_order");
    finish_test("set_order");
    // Test 3 waits for N+1 triggers and then gets a stray trigger
    reset_dut();
    n_trig = int'(rand_bits(3)) + 1;
    push_cmd(make_wait_cmd(NO_OP, 1'b1, 1'b0, count_t'(n_trig)));
    push_cmd(make_wait_cmd(ADC_RD, 1'b0, 1'b0, count_t'(300 + rand_bits(6))));
    wait_flag("trigger_wait", 4, 100);
    for (int i = 0; i <= n_trig; i++) begin
      @(negedge clk);
      check_flag($sformatf("trigger_wait before trigger %0d", i), 1'b1, waiting_for_trig);
      @(posedge clk);
      trigger <= 1'b1;
      @(posedge clk);
      trigger <= 1'b0;
    end
    check_read("trigger_wait");
    @(posedge clk);
    trigger <= 1'b1;  // Nobody waits on this one
    @(posedge clk);
    trigger <= 1'b0;
    wait_flag("trigger_wait unexpected", 2, 100);
    // A read queued during halt must never start a frame
    push_cmd(make_wait_cmd(ADC_RD, 1'b0, 1'b0, count_t'(300 + rand_bits(9))));
    repeat (100) begin
      @(negedge clk);
      if (n_cs !== 1'b1) begin
        $display("trigger_wait: n_cs went low after halt");
        test_errs++;
      end
    end
    finish_test("trigger_wait");
    // Test 4 cancels a long delay
    reset_dut();
    push_cmd(make_wait_cmd(NO_OP, 1'b0, 1'b0, count_t'(1_000_000 + rand_bits(16))));
    push_cmd(make_wait_cmd(CANCEL, 1'b0, 1'b0, '0));
    push_cmd(make_wait_cmd(ADC_RD, 1'b0, 1'b0, count_t'(300 + rand_bits(9))));
    check_read("cancel");
    finish_test("cancel");
    // Test 5 covers the error rules
    reset_dut();
    push_cmd(make_wait_cmd(ADC_RD, 1'b0, 1'b0, count_t'(1)));
    wait_flag("delay_short", 3, 500);
    finish_test("delay_short");
    reset_dut();
    push_cmd(make_wait_cmd(NO_OP, 1'b0, 1'b1, count_t'(5)));
    wait_flag("underflow", 0, 100);
    finish_test("underflow");
    reset_dut();
    @(posedge clk);
    data_buf_full <= 1'b1;
    push_cmd(make_wait_cmd(ADC_RD, 1'b0, 1'b0, count_t'(300 + rand_bits(9))));
    wait_flag("overflow", 1, 3000);
    check_flag("overflow write strobe", 1'b0, wr_seen);
    finish_test("overflow");
    $display("tests run %0d, failed %0d", tests_run, tests_failed);
    if (tests_failed == 0) $display("Testbench passed");
    else $display("Testbench failed");
    $finish;
  end

endmodule

// ==== project.f ====
hw/adc_cmd_pkg.sv
hw/adc_spi_pkg.sv
hw/adc_cmd_sequencer.sv
hw/adc_wait_timers.sv
hw/adc_spi_engine.sv
hw/adc_sample_packer.sv
hw/adc_ctrl_top.sv
+incdir+verif
verif/tb_adc_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_adc_ctrl -f project.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Simulation did not complete"; exit 1; }

cat sim.log
grep -q "Testbench passed" sim.log && exit 0 || exit 1
